//--- Makefile
# Verilator flow for the fetch front end
# Usage: make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
SEED      ?= 99248
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR) -o V$(TOP)

# Fails unless the run prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- fetch_if_stage.sv
/*
 Fetch stage, presents word and PC to decode.
 Outputs are combinational from the live answer or the saved registers.
 Expects at most one answer per request and none while a word is saved.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_if_stage (
	input  wire                      clk,
	input  wire                      arst_n_i,
	input  wire  [31:0]              icpu_dat_i,
	input  wire                      icpu_ack_i,
	input  wire                      icpu_err_i,
	input  wire  [31:0]              icpu_adr_i,
	input  wire  fetch_pkg::itag_e   icpu_tag_i,
	input  wire                      if_freeze_i,
	input  wire                      if_flushpipe_i,
	input  wire                      no_more_dslot_i,
	input  wire                      rfe_i,
	output logic [31:0]              if_insn_o,
	output logic [31:0]              if_pc_o,
	output logic                     if_stall_o,
	output logic                     except_itlbmiss_o,
	output logic                     except_immufault_o,
	output logic                     except_ibuserr_o
);

	import fetch_pkg::*;

	// Any answer this cycle
	logic        answer;
	// Answer arrives under freeze
	logic        save_insn;
	// NOP insertion after flush
	logic        if_bypass;
	logic        bypass_q;
	// Live error decode, bit 0 TLB miss, 1 page fault, 2 bus error
	logic [2:0]  err_live;

	// Saved answer
	logic        saved_q;
	logic [31:0] insn_saved;
	logic [31:0] addr_saved;
	logic [2:0]  err_saved;

	assign answer    = icpu_ack_i || icpu_err_i;
	assign save_insn = answer && if_freeze_i && !saved_q;

	assign err_live[0] = icpu_err_i && (icpu_tag_i == ITAG_TE);
	assign err_live[1] = icpu_err_i && (icpu_tag_i == ITAG_PE);
	assign err_live[2] = icpu_err_i && (icpu_tag_i == ITAG_BE);

	//////////////////////////////////////////////////////////////////////
	// Bypass after flush
	//////////////////////////////////////////////////////////////////////

	// First answer after flush ends the bypass in its own cycle
	assign if_bypass = if_flushpipe_i || (bypass_q && !answer);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			bypass_q <= 1'b0;
		else if (if_flushpipe_i)
			bypass_q <= 1'b1;
		else if (answer)
			bypass_q <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Saved answer
	//////////////////////////////////////////////////////////////////////

	// Flush drops the saved word, a run cycle without new save releases it
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			saved_q <= 1'b0;
		else if (if_flushpipe_i)
			saved_q <= 1'b0;
		else if (save_insn)
			saved_q <= 1'b1;
		else if (!if_freeze_i)
			saved_q <= 1'b0;
	end

	// Payload, only read while saved_q is set
	always_ff @(posedge clk) begin
		if (save_insn) begin
			// Errored fetch carries no usable word
			insn_saved <= icpu_err_i ? INSN_NOP_FLUSH : icpu_dat_i;
			addr_saved <= {icpu_adr_i[31:2], 2'b00};
			err_saved  <= err_live;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs to decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (no_more_dslot_i || rfe_i || if_bypass)
			if_insn_o = INSN_NOP_FLUSH;
		else if (saved_q)
			if_insn_o = insn_saved;
		else if (icpu_ack_i)
			if_insn_o = icpu_dat_i;
		else
			if_insn_o = INSN_NOP_STALL;
	end

	assign if_pc_o    = saved_q ? addr_saved : {icpu_adr_i[31:2], 2'b00};
	// Nothing to hand over yet
	assign if_stall_o = !answer && !saved_q;

	// Exceptions masked at delay slot end
	assign except_itlbmiss_o  = !no_more_dslot_i && (saved_q ? err_saved[0] : err_live[0]);
	assign except_immufault_o = !no_more_dslot_i && (saved_q ? err_saved[1] : err_live[1]);
	assign except_ibuserr_o   = !no_more_dslot_i && (saved_q ? err_saved[2] : err_live[2]);

endmodule

`default_nettype wire

//--- fetch_imem.sv
/*
 Instruction memory model, answers IMEM_LATENCY cycles after a request.
 A new request cancels a pending answer. An answer for an address that no longer
 matches the fetch address is dropped. Contents are only valid once loaded.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_imem (
	input  wire                                clk,
	input  wire                                arst_n_i,
	input  wire                                fetch_req_i,
	input  wire  [31:0]                        fetch_adr_i,
	output logic                               fetch_ack_o,
	output logic                               fetch_err_o,
	output logic [31:0]                        fetch_dat_o,
	output fetch_pkg::itag_e                   fetch_tag_o,
	input  wire                                load_we_i,
	input  wire  [fetch_pkg::IMEM_AW-1:0]      load_adr_i,
	input  wire  [31:0]                        load_dat_i,
	input  wire  fetch_pkg::itag_e             load_tag_i
);

	import fetch_pkg::*;

	// Word array and its tag array
	logic [31:0] mem     [0:(2**IMEM_AW)-1];
	itag_e       tag_mem [0:(2**IMEM_AW)-1];

	// Pending request state
	logic                  busy_q;
	logic [IMEM_CNT_W-1:0] cnt_q;
	logic [31:0]           adr_q;

	// Read side
	logic               answer_due;
	logic               oor;
	logic [IMEM_AW-1:0] rd_idx;
	itag_e              rd_tag;

	//////////////////////////////////////////////////////////////////////
	// Load port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (load_we_i) begin
			mem[load_adr_i]     <= load_dat_i;
			tag_mem[load_adr_i] <= load_tag_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request latch and wait counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (fetch_req_i) begin
			// Restart, older request is lost
			busy_q <= 1'b1;
			cnt_q  <= IMEM_CNT_W'(IMEM_LATENCY - 1);
		end else if (busy_q) begin
			if (cnt_q == '0)
				busy_q <= 1'b0;
			else
				cnt_q <= cnt_q - 1'b1;
		end
	end

	// Request address
	always_ff @(posedge clk) begin
		if (fetch_req_i)
			adr_q <= fetch_adr_i;
	end

	//////////////////////////////////////////////////////////////////////
	// Answer
	//////////////////////////////////////////////////////////////////////

	// Count done and PC unchanged since request
	assign answer_due = busy_q && (cnt_q == '0) && (adr_q == fetch_adr_i);

	// Beyond the array is a bus error
	assign oor    = |adr_q[31:IMEM_AW+2];
	assign rd_idx = adr_q[IMEM_AW+1:2];
	assign rd_tag = oor ? ITAG_BE : tag_mem[rd_idx];

	// Clean tag gives ack, anything else err
	assign fetch_ack_o = answer_due && (rd_tag == ITAG_NONE);
	assign fetch_err_o = answer_due && (rd_tag != ITAG_NONE);
	assign fetch_dat_o = mem[rd_idx];
	assign fetch_tag_o = rd_tag;

endmodule

`default_nettype wire

//--- fetch_pc_gen.sv
/*
 Program counter and request strobe.
 Flush wins over consume. One request pulse per PC change and one after reset.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
	input  wire         clk,
	input  wire         arst_n_i,
	input  wire         flush_i,
	input  wire  [31:0] redirect_pc_i,
	input  wire         freeze_i,
	input  wire         if_stall_i,
	output logic [31:0] fetch_adr_o,
	output logic        fetch_req_o
);

	import fetch_pkg::*;

	// Current PC
	logic [31:0] pc_q;
	// Request still to be issued for pc_q
	logic        req_q;
	// Decode has taken the presented word
	logic        consume;

	//////////////////////////////////////////////////////////////////////
	// Consume detect
	//////////////////////////////////////////////////////////////////////

	// Word taken when pipeline runs and fetch has something
	assign consume = !freeze_i && !if_stall_i;

	//////////////////////////////////////////////////////////////////////
	// PC register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q  <= RESET_PC;
			// First fetch right after reset release
			req_q <= 1'b1;
		end else if (flush_i) begin
			// Redirect, discard whatever is in flight
			pc_q  <= redirect_pc_i;
			req_q <= 1'b1;
		end else if (consume) begin
			// Next sequential word
			pc_q  <= pc_q + 32'd4;
			req_q <= 1'b1;
		end else begin
			// Strobe is a single cycle
			req_q <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////

	// Address held until the next change
	assign fetch_adr_o = pc_q;
	// Pulse in cycle after each change
	assign fetch_req_o = req_q;

endmodule

`default_nettype wire

//--- fetch_pkg.sv
/*
 Shared types and constants for the fetch front end.
 Memory depth and answer latency are fixed here and must be at least 1.
*/
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////////////////////////

	// Major opcodes, only the ones the fetch stage builds words from
	typedef enum logic [5:0] {
		OPC_JUMP = 6'h00,
		OPC_NOP  = 6'h05
	} opcode_e;

	// Fetch answer tags, as returned next to each word
	typedef enum logic [3:0] {
		ITAG_NONE = 4'h0,
		ITAG_BE   = 4'hb,
		ITAG_PE   = 4'hc,
		ITAG_TE   = 4'hd
	} itag_e;

	//////////////////////////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////////////////////////

	// NOP with flush/idle marker
	localparam logic [31:0] INSN_NOP_FLUSH = {OPC_NOP, 26'h041_0000};
	// NOP shown while waiting on memory
	localparam logic [31:0] INSN_NOP_STALL = {OPC_NOP, 26'h061_0000};

	// First fetch address out of reset
	localparam logic [31:0] RESET_PC = 32'h0000_0100;

	// Word address width, 64 words
	localparam int IMEM_AW = 6;
	// Cycles from request to answer
	localparam int IMEM_LATENCY = 2;
	// Wait counter width
	localparam int IMEM_CNT_W = $clog2(IMEM_LATENCY + 1);

endpackage

`default_nettype wire

//--- fetch_top.sv
/*
 Fetch front end top, PC generator, memory model and fetch stage.
 Load port is meant for use while the core idles.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  wire                            clk,
	input  wire                            arst_n_i,
	input  wire                            freeze_i,
	input  wire                            flush_i,
	input  wire  [31:0]                    redirect_pc_i,
	input  wire                            no_more_dslot_i,
	input  wire                            rfe_i,
	input  wire                            load_we_i,
	input  wire  [fetch_pkg::IMEM_AW-1:0]  load_adr_i,
	input  wire  [31:0]                    load_dat_i,
	input  wire  fetch_pkg::itag_e         load_tag_i,
	output logic [31:0]                    insn_o,
	output logic [31:0]                    pc_o,
	output logic                           stall_o,
	output logic                           except_itlbmiss_o,
	output logic                           except_immufault_o,
	output logic                           except_ibuserr_o
);

	import fetch_pkg::*;

	// PC generator to memory
	logic [31:0] fetch_adr;
	logic        fetch_req;
	// Memory answer
	logic        fetch_ack;
	logic        fetch_err;
	logic [31:0] fetch_dat;
	itag_e       fetch_tag;

	fetch_pc_gen u_pc_gen (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.flush_i       (flush_i),
		.redirect_pc_i (redirect_pc_i),
		.freeze_i      (freeze_i),
		.if_stall_i    (stall_o),
		.fetch_adr_o   (fetch_adr),
		.fetch_req_o   (fetch_req)
	);

	fetch_imem u_imem (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.fetch_req_i (fetch_req),
		.fetch_adr_i (fetch_adr),
		.fetch_ack_o (fetch_ack),
		.fetch_err_o (fetch_err),
		.fetch_dat_o (fetch_dat),
		.fetch_tag_o (fetch_tag),
		.load_we_i   (load_we_i),
		.load_adr_i  (load_adr_i),
		.load_dat_i  (load_dat_i),
		.load_tag_i  (load_tag_i)
	);

	// Stall also throttles the PC generator
	fetch_if_stage u_if_stage (
		.clk                (clk),
		.arst_n_i           (arst_n_i),
		.icpu_dat_i         (fetch_dat),
		.icpu_ack_i         (fetch_ack),
		.icpu_err_i         (fetch_err),
		.icpu_adr_i         (fetch_adr),
		.icpu_tag_i         (fetch_tag),
		.if_freeze_i        (freeze_i),
		.if_flushpipe_i     (flush_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.if_insn_o          (insn_o),
		.if_pc_o            (pc_o),
		.if_stall_o         (stall_o),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

endmodule

`default_nettype wire

//--- sources.f
fetch_pkg.sv
fetch_pc_gen.sv
fetch_imem.sv
fetch_if_stage.sv
fetch_top.sv
tb_fetch_top.sv

//--- tb_fetch_top.sv
/*
 Directed testbench for the fetch front end.
 Memory is loaded through the load port while reset is held.
 Words at ERR_IDX..ERR_IDX+2 carry TLB miss, page fault and bus error tags.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top #(
	parameter int SEED = 99248
);

	import fetch_pkg::*;

	localparam int CLK_PERIOD  = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int WAIT_LIMIT  = 200;
	localparam int ERR_IDX     = 48;
	localparam logic [31:0] ERR_BASE = 32'(ERR_IDX * 4);
	// Beyond the 256 byte array
	localparam logic [31:0] OOR_PC   = 32'h0000_0200;
	// Consumed words over all tests for the watchdog budget
	localparam int RUN_WORDS   = 11 + 12 + 8 + 10 + 3;
	localparam int LOAD_CYCLES = 2**IMEM_AW + 8;
	localparam int MARGIN      = 400;

	logic                clk = 1'b0;
	logic                arst_n_i;
	logic                freeze_i;
	logic                flush_i;
	logic [31:0]         redirect_pc_i;
	logic                no_more_dslot_i;
	logic                rfe_i;
	logic                load_we;
	logic [IMEM_AW-1:0]  load_adr;
	logic [31:0]         load_dat;
	itag_e               load_tag;
	logic [31:0]         insn_o;
	logic [31:0]         pc_o;
	logic                stall_o;
	logic                except_itlbmiss_o;
	logic                except_immufault_o;
	logic                except_ibuserr_o;

	// Reference copy of the program
	logic [31:0] ref_dat [0:(2**IMEM_AW)-1];
	itag_e       ref_tag [0:(2**IMEM_AW)-1];

	// Consumed words as seen by decode
	logic [31:0] cons_pc[$];
	logic [31:0] cons_insn[$];
	logic [2:0]  cons_exc[$];

	// Frozen answer tracking
	logic        hold_check = 1'b0;
	logic        held_answer = 1'b0;
	logic [31:0] held_insn;
	logic [31:0] held_pc;

	// Flush NOP tracking until the first answer
	logic        nop_pending = 1'b0;
	string       flush_name = "";

	integer seed = SEED;
	int     errors = 0;
	int     checks = 0;

	fetch_top dut0 (
		.clk                (clk),
		.arst_n_i           (arst_n_i),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.redirect_pc_i      (redirect_pc_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.load_we_i          (load_we),
		.load_adr_i         (load_adr),
		.load_dat_i         (load_dat),
		.load_tag_i         (load_tag),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.stall_o            (stall_o),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Pattern spread over the whole word index
	function automatic logic [31:0] fill_word(input int idx);
		logic [31:0] a;
		a = 32'(idx);
		fill_word = (a * 32'h9e37_79b9) ^ {a[5:0], 26'h155_5555};
	endfunction

	// Bus error out of range and the stored tag elsewhere
	function automatic itag_e expect_tag(input logic [31:0] adr);
		if (|adr[31:IMEM_AW+2])
			expect_tag = ITAG_BE;
		else
			expect_tag = ref_tag[adr[IMEM_AW+1:2]];
	endfunction

	// Bit order {bus error, page fault, TLB miss}
	function automatic logic [2:0] expect_exc(input itag_e tag);
		case (tag)
			ITAG_TE: expect_exc = 3'b001;
			ITAG_PE: expect_exc = 3'b010;
			ITAG_BE: expect_exc = 3'b100;
			default: expect_exc = 3'b000;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Consumed words must follow start + 4k with reference responses
	// Errored words show the stall NOP live and the flush NOP once saved
	task automatic check_run(input string name, input logic [31:0] start, input int n,
			input bit saved);
		logic [31:0] adr;
		itag_e       tag;
		check_value({name, " count"}, 32'(n), 32'(cons_pc.size()));
		for (int k = 0; k < n && k < cons_pc.size(); k++) begin
			adr = start + 32'(4 * k);
			tag = expect_tag(adr);
			check_value({name, " pc"}, adr, cons_pc[k]);
			check_value({name, " exceptions"}, 32'(expect_exc(tag)), 32'(cons_exc[k]));
			if (tag == ITAG_NONE)
				check_value({name, " insn"}, ref_dat[adr[IMEM_AW+1:2]], cons_insn[k]);
			else if (saved)
				check_value({name, " insn"}, INSN_NOP_FLUSH, cons_insn[k]);
			else
				check_value({name, " insn"}, INSN_NOP_STALL, cons_insn[k]);
		end
	endtask

	// Values at the falling edge are what the next rising edge sees
	always @(negedge clk) begin
		if (arst_n_i) begin
			if (hold_check && held_answer) begin
				check_value("freeze_hold stall", 32'd0, 32'(stall_o));
				check_value("freeze_hold insn", held_insn, insn_o);
				check_value("freeze_hold pc", held_pc, pc_o);
			end
			// Stalled cycles after a flush show the flush NOP
			if (flush_i)
				nop_pending = 1'b1;
			else if (!stall_o)
				nop_pending = 1'b0;
			else if (nop_pending)
				check_value({flush_name, " bypass insn"}, INSN_NOP_FLUSH, insn_o);
			// Flush cycle takes nothing
			if (!freeze_i && !stall_o && !flush_i) begin
				cons_pc.push_back(pc_o);
				cons_insn.push_back(insn_o);
				cons_exc.push_back({except_ibuserr_o, except_immufault_o, except_itlbmiss_o});
			end
			held_answer = freeze_i && !stall_o && !flush_i;
			held_insn   = insn_o;
			held_pc     = pc_o;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Drive helpers entered and left just after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic load_memory();
		for (int i = 0; i < 2**IMEM_AW; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			ref_dat[i] = fill_word(i);
			case (i)
				ERR_IDX:     ref_tag[i] = ITAG_TE;
				ERR_IDX + 1: ref_tag[i] = ITAG_PE;
				ERR_IDX + 2: ref_tag[i] = ITAG_BE;
				default:     ref_tag[i] = ITAG_NONE;
			endcase
			load_we  = 1'b1;
			load_adr = IMEM_AW'(i);
			load_dat = ref_dat[i];
			load_tag = ref_tag[i];
		end
		@(posedge clk);
		#DRIVE_DELAY;
		load_we = 1'b0;
	endtask

	task automatic clear_log();
		cons_pc.delete();
		cons_insn.delete();
		cons_exc.delete();
	endtask

	// Single flush cycle where any visible word must be the flush NOP
	task automatic redirect(input logic [31:0] target, input string name);
		flush_name    = name;
		flush_i       = 1'b1;
		redirect_pc_i = target;
		@(negedge clk);
		if (!stall_o)
			check_value({name, " flush insn"}, INSN_NOP_FLUSH, insn_o);
		@(posedge clk);
		#DRIVE_DELAY;
		flush_i = 1'b0;
		clear_log();
	endtask

	// Optional random freeze while waiting
	task automatic wait_count(input int n, input bit rnd);
		int     cyc;
		integer r;
		cyc = 0;
		while (cons_pc.size() < n && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			cyc++;
			if (rnd) begin
				r = $random(seed);
				freeze_i = r[0];
			end
		end
		if (rnd)
			freeze_i = 1'b0;
		if (cons_pc.size() < n) begin
			errors++;
			$display("Timed out waiting for %0d consumed words, got %0d", n, cons_pc.size());
		end
	endtask

	task automatic wait_answer(input string name);
		int cyc;
		cyc = 0;
		while (stall_o && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			cyc++;
		end
		if (stall_o) begin
			errors++;
			$display("%s: no fetch answer arrived within %0d cycles", name, WAIT_LIMIT);
		end
	endtask

	// Freeze over each answer, hold, then release and consume
	task automatic consume_frozen(input int n, input string name);
		int target;
		for (int i = 0; i < n; i++) begin
			freeze_i = 1'b1;
			wait_answer(name);
			repeat (2) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
			check_value({name, " held"}, 32'd0, 32'(stall_o));
			target = cons_pc.size() + 1;
			freeze_i = 1'b0;
			wait_count(target, 1'b0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic sequential_fetch();
		// Reset PC lies outside the array
		wait_count(3, 1'b0);
		check_run("sequential_fetch reset", RESET_PC, 3, 1'b0);
		redirect(32'h40, "sequential_fetch");
		wait_count(8, 1'b0);
		check_run("sequential_fetch", 32'h40, 8, 1'b0);
	endtask

	task automatic freeze_hold();
		redirect(32'h40, "freeze_hold");
		hold_check = 1'b1;
		wait_count(12, 1'b1);
		hold_check = 1'b0;
		check_run("freeze_hold", 32'h40, 12, 1'b0);
	endtask

	task automatic flush_redirect();
		redirect(32'h20, "flush_redirect");
		wait_count(4, 1'b0);
		check_run("flush_redirect", 32'h20, 4, 1'b0);
		// Flush on top of a saved word
		freeze_i = 1'b1;
		wait_answer("flush_redirect");
		@(posedge clk);
		#DRIVE_DELAY;
		redirect(32'h80, "flush_redirect saved");
		freeze_i = 1'b0;
		wait_count(4, 1'b0);
		check_run("flush_redirect saved", 32'h80, 4, 1'b0);
	endtask

	task automatic fetch_errors();
		redirect(ERR_BASE, "fetch_errors");
		wait_count(4, 1'b0);
		check_run("fetch_errors", ERR_BASE, 4, 1'b0);
		redirect(OOR_PC, "fetch_errors range");
		wait_count(2, 1'b0);
		check_run("fetch_errors range", OOR_PC, 2, 1'b0);
		redirect(ERR_BASE, "fetch_errors frozen");
		consume_frozen(4, "fetch_errors frozen");
		check_run("fetch_errors frozen", ERR_BASE, 4, 1'b1);
	endtask

	task automatic dslot_and_rfe();
		logic [31:0] adr;
		no_more_dslot_i = 1'b1;
		redirect(ERR_BASE, "dslot_and_rfe");
		wait_count(1, 1'b0);
		consume_frozen(1, "dslot_and_rfe");
		no_more_dslot_i = 1'b0;
		rfe_i = 1'b1;
		wait_count(3, 1'b0);
		rfe_i = 1'b0;
		check_value("dslot_and_rfe count", 32'd3, 32'(cons_pc.size()));
		for (int k = 0; k < 3 && k < cons_pc.size(); k++) begin
			adr = ERR_BASE + 32'(4 * k);
			check_value("dslot_and_rfe pc", adr, cons_pc[k]);
			check_value("dslot_and_rfe insn", INSN_NOP_FLUSH, cons_insn[k]);
			// Delay slot end masks exceptions but return from exception does not
			if (k < 2)
				check_value("dslot_and_rfe exceptions", 32'd0, 32'(cons_exc[k]));
			else
				check_value("dslot_and_rfe exceptions",
					32'(expect_exc(expect_tag(adr))), 32'(cons_exc[k]));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog and main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		#((LOAD_CYCLES + RUN_WORDS * (IMEM_LATENCY + 3) + MARGIN) * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		arst_n_i        = 1'b0;
		freeze_i        = 1'b0;
		flush_i         = 1'b0;
		redirect_pc_i   = 32'd0;
		no_more_dslot_i = 1'b0;
		rfe_i           = 1'b0;
		load_we         = 1'b0;
		load_adr        = '0;
		load_dat        = 32'd0;
		load_tag        = ITAG_NONE;

		load_memory();
		repeat (4) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		arst_n_i = 1'b1;

		// Idle state out of reset
		check_value("reset stall", 32'd1, 32'(stall_o));
		check_value("reset insn", INSN_NOP_STALL, insn_o);
		check_value("reset exceptions", 32'd0,
			32'({except_ibuserr_o, except_immufault_o, except_itlbmiss_o}));
		check_value("reset answer", 32'd0, 32'({dut0.fetch_ack, dut0.fetch_err}));

		sequential_fetch();
		freeze_hold();
		flush_redirect();
		fetch_errors();
		dslot_and_rfe();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
